//--- common/fma_settings.svh
// ----------------------------------------------------------
// Format and datapath widths of the FP16 FMA unit
// Included by the package and by modules sizing the datapath
// ----------------------------------------------------------
`ifndef FMA_SETTINGS_SVH
`define FMA_SETTINGS_SVH

// FP16 format fields
`define FMA_EXP_BITS 5
`define FMA_MAN_BITS 10
`define FMA_BIAS 15

// Precision with hidden bit
`define FMA_PREC 11
// Wide adder, 3p+4
`define FMA_SUM_W 37
// Leading-zero search window, 2p+3
`define FMA_LOWER_W 25
// Signed internal exponent and shift amounts
`define FMA_EXP_W 7
`define FMA_SHAMT_W 6

`endif

//--- common/fma_pkg.sv
// ----------------------------------------------------------
// Shared types of the FMA pipeline: operands, classes, flags
// and the payloads passed between the stages
// ----------------------------------------------------------
`include "fma_settings.svh"

package fma_pkg;

  typedef struct packed {
    logic                       sign;
    logic [`FMA_EXP_BITS-1:0]   exponent;
    logic [`FMA_MAN_BITS-1:0]   mantissa;
  } fp16_t;

  // Operand class, one hot except for the signalling bit
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // IEEE exception flags
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  // op_mod turns these into FMSUB, FNMADD and SUB
  typedef enum logic [1:0] {
    FMADD,
    FNMSUB,
    ADD,
    MUL
  } fma_op_e;

  typedef struct packed {
    fp16_t      a;
    fp16_t      b;
    fp16_t      c;
    fma_op_e    op;
    logic       op_mod;
    roundmode_e rnd_mode;
  } fma_req_t;

  // Adjusted operands plus the bypass result
  typedef struct packed {
    fp16_t      a;
    fp16_t      b;
    fp16_t      c;
    fp_info_t   info_a;
    fp_info_t   info_b;
    fp_info_t   info_c;
    roundmode_e rnd_mode;
    logic       special;
    fp16_t      special_result;
    status_t    special_status;
  } fma_dec_t;

  // Middle register payload
  typedef struct packed {
    logic                          effective_subtraction;
    logic signed [`FMA_EXP_W-1:0]  exponent_product;
    logic signed [`FMA_EXP_W-1:0]  exponent_difference;
    logic signed [`FMA_EXP_W-1:0]  tentative_exponent;
    logic [`FMA_SHAMT_W-1:0]       addend_shamt;
    logic                          sticky_before_add;
    logic [`FMA_SUM_W-1:0]         sum;
    logic                          final_sign;
    roundmode_e                    rnd_mode;
    logic                          is_special;
    fp16_t                         special_result;
    status_t                       special_status;
  } fma_mid_t;

  typedef struct packed {
    fp16_t   result;
    status_t status;
  } fma_rsp_t;

endpackage

//--- design/fma_decode.sv
// ----------------------------------------------------------
// Combinational decode stage: opcode operand adjustment,
// operand classes and the special-case bypass result
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fma_settings.svh"

module fma_decode import fma_pkg::*; (
  input  fma_req_t req_i,
  output fma_dec_t dec_o
);

  // Class bits from the exponent and mantissa fields
  function automatic fp_info_t classify(fp16_t x);
    fp_info_t info;
    logic     exp_ones;
    logic     exp_zero;
    logic     man_zero;
    exp_ones           = &x.exponent;
    exp_zero           = ~|x.exponent;
    man_zero           = ~|x.mantissa;
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = info.is_nan && !x.mantissa[`FMA_MAN_BITS-1];
    return info;
  endfunction

  fp16_t    a, b, c;
  fp_info_t info_a, info_b, info_c;
  logic     any_inf, any_nan, any_snan;
  logic     eff_sub;

  // ----------------------------------------------------------
  // Operand adjustment
  // ----------------------------------------------------------
  always_comb begin : op_select
    a = req_i.a;
    b = req_i.b;
    c = req_i.c;
    // op_mod always negates the addend
    c.sign = c.sign ^ req_i.op_mod;
    unique case (req_i.op)
      FMADD:  ;
      FNMSUB: a.sign = ~a.sign;
      // Multiplicand forced to +1.0
      ADD:    a = '{sign: 1'b0, exponent: `FMA_EXP_BITS'(`FMA_BIAS), mantissa: '0};
      // Addend -0 keeps the sign of a zero product under RDN
      MUL:    c = '{sign: 1'b1, exponent: '0, mantissa: '0};
    endcase
  end

  // Sign plays no part in the class, so classify after adjustment
  assign info_a = classify(a);
  assign info_b = classify(b);
  assign info_c = classify(c);

  assign any_inf  = info_a.is_inf | info_b.is_inf | info_c.is_inf;
  assign any_nan  = info_a.is_nan | info_b.is_nan | info_c.is_nan;
  assign any_snan = info_a.is_signalling | info_b.is_signalling | info_c.is_signalling;
  assign eff_sub  = a.sign ^ b.sign ^ c.sign;

  // ----------------------------------------------------------
  // Special cases, inf*0 first, then NaN, then infinities
  // ----------------------------------------------------------
  always_comb begin : special_cases
    dec_o.a        = a;
    dec_o.b        = b;
    dec_o.c        = c;
    dec_o.info_a   = info_a;
    dec_o.info_b   = info_b;
    dec_o.info_c   = info_c;
    dec_o.rnd_mode = req_i.rnd_mode;
    // Canonical quiet NaN, 16'h7E00
    dec_o.special_result = '{sign: 1'b0, exponent: '1,
                             mantissa: {1'b1, {(`FMA_MAN_BITS-1){1'b0}}}};
    dec_o.special_status = '0;
    dec_o.special        = 1'b0;
    if ((info_a.is_inf && info_b.is_zero) || (info_a.is_zero && info_b.is_inf)) begin
      // Invalid whatever the addend, even a quiet NaN
      dec_o.special           = 1'b1;
      dec_o.special_status.NV = 1'b1;
    end else if (any_nan) begin
      dec_o.special           = 1'b1;
      dec_o.special_status.NV = any_snan;
    end else if (any_inf) begin
      dec_o.special = 1'b1;
      if ((info_a.is_inf || info_b.is_inf) && info_c.is_inf && eff_sub) begin
        // inf - inf
        dec_o.special_status.NV = 1'b1;
      end else if (info_a.is_inf || info_b.is_inf) begin
        dec_o.special_result = '{sign: a.sign ^ b.sign, exponent: '1, mantissa: '0};
      end else begin
        dec_o.special_result = '{sign: c.sign, exponent: '1, mantissa: '0};
      end
    end
  end

endmodule

//--- design/fma_execute.sv
// ----------------------------------------------------------
// Exponent datapath, 11x11 product, addend alignment and the
// wide adder, registered in the middle pipeline stage
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fma_settings.svh"

module fma_execute import fma_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  fma_dec_t dec_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output fma_mid_t mid_o,
  output logic     mid_valid_o,
  input  logic     mid_ready_i
);

  logic signed [`FMA_EXP_W-1:0] exponent_a, exponent_b, exponent_c;
  logic signed [`FMA_EXP_W-1:0] exponent_addend, exponent_product;
  logic signed [`FMA_EXP_W-1:0] exponent_difference, tentative_exponent;
  logic [`FMA_SHAMT_W-1:0]      addend_shamt;
  logic [`FMA_PREC-1:0]         mantissa_a, mantissa_b, mantissa_c;
  logic [2*`FMA_PREC-1:0]       product;
  logic [`FMA_SUM_W-1:0]        product_shifted, addend_after_shift, addend_shifted;
  logic [`FMA_PREC-1:0]         addend_sticky_bits;
  logic                         sticky_before_add, inject_carry_in;
  logic                         effective_subtraction, tentative_sign;
  logic [`FMA_SUM_W:0]          sum_raw;
  logic [`FMA_SUM_W-1:0]        sum;
  logic                         sum_carry, final_sign;
  fma_mid_t                     mid_d;

  assign effective_subtraction = dec_i.a.sign ^ dec_i.b.sign ^ dec_i.c.sign;
  // Product sign is the first guess
  assign tentative_sign = dec_i.a.sign ^ dec_i.b.sign;

  // ----------------------------------------------------------
  // Exponents, kept biased
  // ----------------------------------------------------------
  assign exponent_a = signed'({2'b00, dec_i.a.exponent});
  assign exponent_b = signed'({2'b00, dec_i.b.exponent});
  assign exponent_c = signed'({2'b00, dec_i.c.exponent});

  // Subnormal and zero addend sit at exponent 1
  assign exponent_addend = `FMA_EXP_W'(exponent_c + !dec_i.info_c.is_normal);
  // Zero product takes the minimum exponent
  assign exponent_product = (dec_i.info_a.is_zero || dec_i.info_b.is_zero) ?
      `FMA_EXP_W'(2 - `FMA_BIAS) :
      `FMA_EXP_W'(exponent_a + dec_i.info_a.is_subnormal + exponent_b
                  + dec_i.info_b.is_subnormal - `FMA_BIAS);
  assign exponent_difference = exponent_addend - exponent_product;
  assign tentative_exponent  = (exponent_difference > 0) ? exponent_addend : exponent_product;

  always_comb begin : addend_shift_amount
    if (exponent_difference <= -(2 * `FMA_PREC) - 1) begin
      // Addend lands in the sticky bit only
      addend_shamt = `FMA_SHAMT_W'(3 * `FMA_PREC + 4);
    end else if (exponent_difference <= `FMA_PREC + 2) begin
      addend_shamt = `FMA_SHAMT_W'(`FMA_PREC + 3 - exponent_difference);
    end else begin
      // Addend anchored, product falls below it
      addend_shamt = '0;
    end
  end

  // ----------------------------------------------------------
  // Product and aligned addend
  // ----------------------------------------------------------
  assign mantissa_a = {dec_i.info_a.is_normal, dec_i.a.mantissa};
  assign mantissa_b = {dec_i.info_b.is_normal, dec_i.b.mantissa};
  assign mantissa_c = {dec_i.info_c.is_normal, dec_i.c.mantissa};

  // Full product, no truncation
  assign product = mantissa_a * mantissa_b;
  // Layout: p+2 zeros, 2p product, round and sticky slots
  assign product_shifted = {{(`FMA_PREC+2){1'b0}}, product, 2'b00};

  // Up to p bits of the addend fall out into the sticky bits
  assign {addend_after_shift, addend_sticky_bits} =
      {mantissa_c, {`FMA_SUM_W{1'b0}}} >> addend_shamt;
  assign sticky_before_add = |addend_sticky_bits;

  // Ones' complement plus carry-in, no carry when sticky bits were lost
  assign addend_shifted  = effective_subtraction ? ~addend_after_shift : addend_after_shift;
  assign inject_carry_in = effective_subtraction & ~sticky_before_add;

  // ----------------------------------------------------------
  // Adder and sign fix
  // ----------------------------------------------------------
  assign sum_raw = {1'b0, product_shifted} + {1'b0, addend_shifted}
                   + {{`FMA_SUM_W{1'b0}}, inject_carry_in};
  assign sum_carry = sum_raw[`FMA_SUM_W];
  // No carry out of a subtraction means a negative sum
  assign sum = (effective_subtraction && !sum_carry) ?
               -sum_raw[`FMA_SUM_W-1:0] : sum_raw[`FMA_SUM_W-1:0];
  assign final_sign = effective_subtraction ? (sum_carry == tentative_sign) : tentative_sign;

  always_comb begin : mid_pack
    mid_d.effective_subtraction = effective_subtraction;
    mid_d.exponent_product      = exponent_product;
    mid_d.exponent_difference   = exponent_difference;
    mid_d.tentative_exponent    = tentative_exponent;
    mid_d.addend_shamt          = addend_shamt;
    mid_d.sticky_before_add     = sticky_before_add;
    mid_d.sum                   = sum;
    mid_d.final_sign            = final_sign;
    mid_d.rnd_mode              = dec_i.rnd_mode;
    mid_d.is_special            = dec_i.special;
    mid_d.special_result        = dec_i.special_result;
    mid_d.special_status        = dec_i.special_status;
  end

  // ----------------------------------------------------------
  // Middle register
  // ----------------------------------------------------------
  // Ready when downstream takes data or a bubble can be popped
  assign in_ready_o = mid_ready_i | ~mid_valid_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mid_valid_o <= 1'b0;
      mid_o       <= '0;
    end else begin
      if (in_ready_o) begin
        mid_valid_o <= in_valid_i;
      end
      if (in_ready_o && in_valid_i) begin
        mid_o <= mid_d;
      end
    end
  end

endmodule

//--- design/fma_result/fma_round.sv
// ----------------------------------------------------------
// Rounds the 15-bit magnitude by mode and round/sticky bits
// Also fixes the sign of an exact zero difference
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fma_settings.svh"

module fma_round import fma_pkg::*; (
  input  logic [`FMA_EXP_BITS+`FMA_MAN_BITS-1:0] abs_i,
  input  logic                                   sign_i,
  input  logic [1:0]                             round_sticky_i,
  input  roundmode_e                             rnd_mode_i,
  input  logic                                   eff_sub_i,
  output logic [`FMA_EXP_BITS+`FMA_MAN_BITS-1:0] abs_o,
  output logic                                   sign_o,
  output logic                                   exact_zero_o
);

  logic round_up;

  always_comb begin : round_decision
    unique case (rnd_mode_i)
      // Ties to even, round bit set and sticky clear is a tie
      RNE: round_up = round_sticky_i[1] & (round_sticky_i[0] | abs_i[0]);
      RTZ: round_up = 1'b0;
      // Toward the infinity of matching sign
      RDN: round_up = (|round_sticky_i) & sign_i;
      RUP: round_up = (|round_sticky_i) & ~sign_i;
      // Ties away from zero
      RMM: round_up = round_sticky_i[1];
      default: round_up = 1'b0;
    endcase
  end

  // A mantissa carry moves into the exponent field on its own
  assign abs_o = abs_i + {{(`FMA_EXP_BITS+`FMA_MAN_BITS-1){1'b0}}, round_up};

  assign exact_zero_o = (abs_i == '0) && (round_sticky_i == 2'b00);

  // x - x is +0, except -0 when rounding down
  assign sign_o = (exact_zero_o && eff_sub_i) ? (rnd_mode_i == RDN) : sign_i;

endmodule

//--- design/fma_result/fma_result.sv
// ----------------------------------------------------------
// Result stage: leading-zero normalisation, rounding, flags
// and result selection into the output register
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fma_settings.svh"

module fma_result import fma_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  fma_mid_t mid_i,
  input  logic     mid_valid_i,
  output logic     mid_ready_o,
  output fma_rsp_t rsp_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  logic signed [`FMA_EXP_W-1:0]          exp_prod, exp_diff, exp_tent;
  logic [`FMA_LOWER_W-1:0]               sum_lower;
  logic [`FMA_SHAMT_W-1:0]               lz_count, norm_shamt;
  logic signed [`FMA_EXP_W-1:0]          lz_sgn, normalized_exponent, final_exponent;
  logic                                  lzc_zeroes;
  logic [`FMA_SUM_W:0]                   sum_shifted;
  logic [`FMA_PREC:0]                    final_mantissa;
  logic [`FMA_LOWER_W-1:0]               sum_sticky_bits;
  logic                                  sticky_after_norm;
  logic                                  of_before_round, of_after_round, uf_after_round;
  logic [`FMA_EXP_BITS-1:0]              pre_round_exponent;
  logic [`FMA_MAN_BITS-1:0]              pre_round_mantissa;
  logic [1:0]                            round_sticky_bits;
  logic [`FMA_EXP_BITS+`FMA_MAN_BITS-1:0] rounded_abs;
  logic                                  rounded_sign;
  status_t                               regular_status;
  fma_rsp_t                              rsp_d;

  assign exp_prod  = mid_i.exponent_product;
  assign exp_diff  = mid_i.exponent_difference;
  assign exp_tent  = mid_i.tentative_exponent;
  assign sum_lower = mid_i.sum[`FMA_LOWER_W-1:0];

  // ----------------------------------------------------------
  // Leading-zero count, highest set bit wins
  // ----------------------------------------------------------
  always_comb begin : lzc
    lz_count   = '0;
    lzc_zeroes = 1'b1;
    for (int i = 0; i < `FMA_LOWER_W; i++) begin
      if (sum_lower[i]) begin
        lz_count   = `FMA_SHAMT_W'(`FMA_LOWER_W - 1 - i);
        lzc_zeroes = 1'b0;
      end
    end
  end

  assign lz_sgn = signed'({1'b0, lz_count});

  always_comb begin : norm_shift_amount
    if ((exp_diff <= 0) || (mid_i.effective_subtraction && (exp_diff <= 2))) begin
      // Product anchored or cancellation
      if ((exp_prod - lz_sgn + 1 >= 0) && !lzc_zeroes) begin
        norm_shamt          = `FMA_SHAMT_W'(`FMA_PREC + 2 + lz_count);
        normalized_exponent = `FMA_EXP_W'(exp_prod - lz_sgn + 1);
      end else begin
        // Subnormal, shift capped at the minimum exponent
        norm_shamt          = `FMA_SHAMT_W'(`FMA_PREC + 2 + exp_prod);
        normalized_exponent = '0;
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt          = mid_i.addend_shamt;
      normalized_exponent = exp_tent;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum} << norm_shamt;

  // Leading one may sit one bit off the sum MSB
  always_comb begin : small_norm
    {final_mantissa, sum_sticky_bits} = sum_shifted[`FMA_SUM_W-1:0];
    final_exponent                    = normalized_exponent;
    if (sum_shifted[`FMA_SUM_W]) begin
      {final_mantissa, sum_sticky_bits} = sum_shifted[`FMA_SUM_W:1];
      final_exponent                    = `FMA_EXP_W'(normalized_exponent + 1);
    end else if (sum_shifted[`FMA_SUM_W-1]) begin
      final_exponent = normalized_exponent;
    end else if (normalized_exponent > 1) begin
      {final_mantissa, sum_sticky_bits} = {sum_shifted[`FMA_SUM_W-2:0], 1'b0};
      final_exponent                    = `FMA_EXP_W'(normalized_exponent - 1);
    end else begin
      final_exponent = '0;
    end
  end

  assign sticky_after_norm = (|sum_sticky_bits) | mid_i.sticky_before_add;

  // ----------------------------------------------------------
  // Rounding
  // ----------------------------------------------------------
  assign of_before_round = final_exponent >= (2 ** `FMA_EXP_BITS) - 1;

  // Overflow saturates to the largest normal, R and S forced high
  assign pre_round_exponent = of_before_round ? `FMA_EXP_BITS'((2 ** `FMA_EXP_BITS) - 2) :
                              final_exponent[`FMA_EXP_BITS-1:0];
  assign pre_round_mantissa = of_before_round ? '1 : final_mantissa[`FMA_MAN_BITS:1];
  assign round_sticky_bits  = of_before_round ? 2'b11 : {final_mantissa[0], sticky_after_norm};

  fma_round u_round (
    .abs_i          ({pre_round_exponent, pre_round_mantissa}),
    .sign_i         (mid_i.final_sign),
    .round_sticky_i (round_sticky_bits),
    .rnd_mode_i     (mid_i.rnd_mode),
    .eff_sub_i      (mid_i.effective_subtraction),
    .abs_o          (rounded_abs),
    .sign_o         (rounded_sign),
    .exact_zero_o   ()
  );

  // Underflow is judged after rounding
  assign uf_after_round = rounded_abs[`FMA_EXP_BITS+`FMA_MAN_BITS-1:`FMA_MAN_BITS] == '0;
  assign of_after_round = rounded_abs[`FMA_EXP_BITS+`FMA_MAN_BITS-1:`FMA_MAN_BITS] == '1;

  assign regular_status.NV = 1'b0;
  assign regular_status.DZ = 1'b0;
  assign regular_status.OF = of_before_round | of_after_round;
  // Inexact when round or sticky bits were dropped, or on overflow
  assign regular_status.NX = (|round_sticky_bits) | of_before_round | of_after_round;
  assign regular_status.UF = uf_after_round & regular_status.NX;

  assign rsp_d.result = mid_i.is_special ? mid_i.special_result : {rounded_sign, rounded_abs};
  assign rsp_d.status = mid_i.is_special ? mid_i.special_status : regular_status;

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------
  assign mid_ready_o = out_ready_i | ~out_valid_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      if (mid_ready_o) begin
        out_valid_o <= mid_valid_i;
      end
      if (mid_ready_o && mid_valid_i) begin
        rsp_o <= rsp_d;
      end
    end
  end

endmodule

//--- design/fma_top.sv
// ----------------------------------------------------------
// FP16 fused multiply-add, two cycles from request to result
// Requests and responses use valid/ready handshakes
// ----------------------------------------------------------
`timescale 1ns/1ps

module fma_top import fma_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  fma_req_t req_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output fma_rsp_t rsp_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  fma_dec_t dec;
  fma_mid_t mid;
  logic     mid_valid;
  logic     mid_ready;

  // Operand adjustment and special cases, no register
  fma_decode u_decode (
    .req_i (req_i),
    .dec_o (dec)
  );

  // Product, alignment, adder and middle register
  fma_execute u_execute (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .dec_i       (dec),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .mid_o       (mid),
    .mid_valid_o (mid_valid),
    .mid_ready_i (mid_ready)
  );

  // Normalisation, rounding and output register
  fma_result u_result (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .mid_i       (mid),
    .mid_valid_i (mid_valid),
    .mid_ready_o (mid_ready),
    .rsp_o       (rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

endmodule

//--- dv/fma_checker.sv
// ----------------------------------------------------------
// Handshake and NaN assertions, bound into the FMA top level
// ----------------------------------------------------------
`timescale 1ns/1ps

module fma_checker import fma_pkg::*; (
  input logic     clk_i,
  input logic     arst_n_i,
  input fma_rsp_t rsp_o,
  input logic     out_valid_o,
  input logic     out_ready_i
);

  // Read by the testbench at the end of the run
  int assert_failures = 0;

  // Output register stays empty while reset is held
  reset_empty: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_o)
    else begin
      $error("out_valid_o high while arst_n_i is low");
      assert_failures++;
    end

  // Stalled response keeps its data and valid
  stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o))
    else begin
      $error("rsp_o or out_valid_o changed while stalled");
      assert_failures++;
    end

  // Invalid operation always yields the canonical quiet NaN
  nv_quiet_nan: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o && rsp_o.status.NV |-> rsp_o.result == 16'h7E00)
    else begin
      $error("NV response without canonical NaN");
      assert_failures++;
    end

endmodule

bind fma_top fma_checker u_checker (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .rsp_o       (rsp_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i)
);

//--- dv/fma_tb.sv
// ----------------------------------------------------------
// Directed testbench of the FP16 FMA unit with stall checks
// Runs standalone, prints one line per test and a summary
// ----------------------------------------------------------
`timescale 1ns/1ps

module fma_tb import fma_pkg::*; ();

  localparam int RESET_CYCLES   = 5;
  // About 200 cycles of tests, ten times margin
  localparam int TIMEOUT_CYCLES = 2000;

  // Flag order is NV DZ OF UF NX
  localparam status_t NO_FLAGS   = 5'b00000;
  localparam status_t FLAG_NV    = 5'b10000;
  localparam status_t FLAG_NX    = 5'b00001;
  localparam status_t FLAG_OF_NX = 5'b00101;
  localparam status_t FLAG_UF_NX = 5'b00011;

  logic     clk_i;
  logic     arst_n_i;
  fma_req_t req_i;
  logic     in_valid_i;
  logic     in_ready_o;
  fma_rsp_t rsp_o;
  logic     out_valid_o;
  logic     out_ready_i;

  int cycle_count = 0;
  int error_count = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  // Pending batch, requests with their expected responses
  fma_req_t req_q[$];
  fma_rsp_t exp_q[$];
  string    name_q[$];

  fma_top uut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .rsp_o       (rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic compare_result(input fp16_t got, input fp16_t expected, input string what);
    if (got !== expected) begin
      $display("mismatch at %0t: %s result %h, expected %h", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic compare_status(input status_t got, input status_t expected,
                                input string what);
    if (got !== expected) begin
      $display("mismatch at %0t: %s status %b, expected %b", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic add_case(input string name, input fma_op_e op, input logic op_mod,
                          input roundmode_e rm, input logic [15:0] a, input logic [15:0] b,
                          input logic [15:0] c, input logic [15:0] result,
                          input status_t status);
    fma_req_t req;
    fma_rsp_t rsp;
    req.a        = a;
    req.b        = b;
    req.c        = c;
    req.op       = op;
    req.op_mod   = op_mod;
    req.rnd_mode = rm;
    rsp.result   = result;
    rsp.status   = status;
    req_q.push_back(req);
    exp_q.push_back(rsp);
    name_q.push_back(name);
  endtask

  // Issues the batch back to back, checks responses in order
  task automatic run_batch(input bit stall);
    int n;
    int sent;
    int received;
    int latency;
    int accept_cycle[$];
    bit in_fire;
    bit out_fire;
    n        = req_q.size();
    sent     = 0;
    received = 0;
    while (received < n) begin
      // Outputs are settled at the falling edge
      @(negedge clk_i);
      in_fire  = in_valid_i && in_ready_o;
      out_fire = out_valid_o && out_ready_i;
      if (out_fire) begin
        compare_result(rsp_o.result, exp_q[received].result, name_q[received]);
        compare_status(rsp_o.status, exp_q[received].status, name_q[received]);
        // Edge count of the output transfer minus that of the acceptance
        latency = cycle_count + 1 - accept_cycle.pop_front();
        if (!stall && latency != 2) begin
          $display("mismatch at %0t: %s arrived %0d cycles after acceptance, expected 2",
                   $time, name_q[received], latency);
          error_count++;
        end
        received++;
      end
      if (in_fire) begin
        accept_cycle.push_back(cycle_count + 1);
        sent++;
      end
      @(posedge clk_i);
      in_valid_i <= (sent < n);
      if (sent < n) begin
        req_i <= req_q[sent];
      end
      out_ready_i <= stall ? ($urandom_range(0, 2) != 0) : 1'b1;
    end
    out_ready_i <= 1'b1;
    req_q.delete();
    exp_q.delete();
    name_q.delete();
  endtask

  task automatic report_test(input string name, input int errors_before);
    int errors;
    errors = error_count - errors_before;
    if (errors == 0) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors);
    end
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  // Exact results, ADD ignores a and computes 1.0*b + c
  task automatic queue_arith_case(input int idx);
    case (idx)
      0: add_case("fmadd 2*3+1", FMADD, 1'b0, RNE, 16'h4000, 16'h4200, 16'h3C00,
                  16'h4700, NO_FLAGS);
      1: add_case("fmsub 2*3-1", FMADD, 1'b1, RNE, 16'h4000, 16'h4200, 16'h3C00,
                  16'h4500, NO_FLAGS);
      2: add_case("fnmsub -2*3+1", FNMSUB, 1'b0, RNE, 16'h4000, 16'h4200, 16'h3C00,
                  16'hC500, NO_FLAGS);
      3: add_case("add 1.5+2.25", ADD, 1'b0, RNE, 16'h0000, 16'h3E00, 16'h4080,
                  16'h4380, NO_FLAGS);
      4: add_case("sub 1-1 rne", ADD, 1'b1, RNE, 16'h0000, 16'h3C00, 16'h3C00,
                  16'h0000, NO_FLAGS);
      5: add_case("sub 1-1 rdn", ADD, 1'b1, RDN, 16'h0000, 16'h3C00, 16'h3C00,
                  16'h8000, NO_FLAGS);
      default: add_case("mul 1.5*-2", MUL, 1'b0, RNE, 16'h3E00, 16'hC000, 16'h0000,
                        16'hC200, NO_FLAGS);
    endcase
  endtask

  task automatic test_exact_arith();
    int errors_before;
    errors_before = error_count;
    for (int i = 0; i < 7; i++) begin
      queue_arith_case(i);
    end
    run_batch(1'b0);
    report_test("exact_arith", errors_before);
  endtask

  task automatic test_special_cases();
    int errors_before;
    errors_before = error_count;
    add_case("inf*0+nan", FMADD, 1'b0, RNE, 16'h7C00, 16'h0000, 16'h7E00,
             16'h7E00, FLAG_NV);
    add_case("quiet nan", FMADD, 1'b0, RNE, 16'h7E00, 16'h3C00, 16'h3C00,
             16'h7E00, NO_FLAGS);
    add_case("signalling nan", FMADD, 1'b0, RNE, 16'h7C01, 16'h3C00, 16'h3C00,
             16'h7E00, FLAG_NV);
    add_case("inf-inf", ADD, 1'b1, RNE, 16'h0000, 16'h7C00, 16'h7C00, 16'h7E00, FLAG_NV);
    add_case("inf*2+1", FMADD, 1'b0, RNE, 16'h7C00, 16'h4000, 16'h3C00,
             16'h7C00, NO_FLAGS);
    run_batch(1'b0);
    report_test("special_cases", errors_before);
  endtask

  // 1.0 + 2^-11 sits halfway between 1.0 and 1.0 + 2^-10
  task automatic test_rounding_modes();
    int errors_before;
    errors_before = error_count;
    add_case("tie rne", ADD, 1'b0, RNE, 16'h0000, 16'h3C00, 16'h1000, 16'h3C00, FLAG_NX);
    add_case("tie rtz", ADD, 1'b0, RTZ, 16'h0000, 16'h3C00, 16'h1000, 16'h3C00, FLAG_NX);
    add_case("tie rdn", ADD, 1'b0, RDN, 16'h0000, 16'h3C00, 16'h1000, 16'h3C00, FLAG_NX);
    add_case("tie rup", ADD, 1'b0, RUP, 16'h0000, 16'h3C00, 16'h1000, 16'h3C01, FLAG_NX);
    add_case("tie rmm", ADD, 1'b0, RMM, 16'h0000, 16'h3C00, 16'h1000, 16'h3C01, FLAG_NX);
    add_case("negative tie rdn", ADD, 1'b0, RDN, 16'h0000, 16'hBC00, 16'h9000,
             16'hBC01, FLAG_NX);
    run_batch(1'b0);
    report_test("rounding_modes", errors_before);
  endtask

  task automatic test_range_limits();
    int errors_before;
    errors_before = error_count;
    // 65504 * 2 is past the largest normal
    add_case("overflow rne", MUL, 1'b0, RNE, 16'h7BFF, 16'h4000, 16'h0000,
             16'h7C00, FLAG_OF_NX);
    add_case("overflow rtz", MUL, 1'b0, RTZ, 16'h7BFF, 16'h4000, 16'h0000,
             16'h7BFF, FLAG_OF_NX);
    // 2^-14 * 2^-7 = 2^-21, eight subnormal steps
    add_case("exact subnormal", MUL, 1'b0, RNE, 16'h0400, 16'h2000, 16'h0000,
             16'h0008, NO_FLAGS);
    // 2^-24 * (1 + 2^-10) loses its low bit
    add_case("inexact subnormal", MUL, 1'b0, RNE, 16'h0401, 16'h1400, 16'h0000,
             16'h0001, FLAG_UF_NX);
    run_batch(1'b0);
    report_test("range_limits", errors_before);
  endtask

  task automatic test_backpressure();
    int errors_before;
    errors_before = error_count;
    for (int i = 0; i < 20; i++) begin
      queue_arith_case(i % 7);
    end
    run_batch(1'b1);
    report_test("backpressure", errors_before);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(32'h2f5c));
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    req_i       = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;

    test_exact_arith();
    test_special_cases();
    test_rounding_modes();
    test_range_limits();
    test_backpressure();

    $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, uut.u_checker.assert_failures);
    if (tests_failed == 0 && uut.u_checker.assert_failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+common
common/fma_pkg.sv
design/fma_decode.sv
design/fma_execute.sv
design/fma_result/fma_round.sv
design/fma_result/fma_result.sv
design/fma_top.sv
dv/fma_checker.sv
dv/fma_tb.sv

//--- Makefile
SIM      := verilator
TOP      := fma_tb
FILELIST := compile.f
FLAGS    := --binary --timing --assert -Wno-fatal
PASS_MSG := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
